/* source/core_config.svh */
// Core widths and sizes: data word, program address, register index,
// program memory depth and the register range reported to the peripheral

`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// Data word
`define XLEN 32

// Program address in words, the byte PC adds two low bits
`define ADDR_BITS 10

// Register index
`define REG_SEL_BITS 5

// Program memory depth in words
`define IMEM_WORDS 1024

// Writes to a0..a7 go out on the peripheral port
`define PERIPH_REG_FIRST 10
`define PERIPH_REG_LAST 17

`endif

/* source/core_pkg.sv */
// Core types: major opcodes, ALU operations and next-PC selection
`default_nettype none

package core_pkg;

  // RV32I major opcodes the core executes
  typedef enum logic [6:0] {
    OPC_OP      = 7'b0110011,
    OPC_OP_IMM  = 7'b0010011,
    OPC_LUI     = 7'b0110111,
    OPC_JAL     = 7'b1101111,
    OPC_BRANCH  = 7'b1100011,
    OPC_ILLEGAL = 7'b0000000
  } opcode_e;

  // ALU operations, PASS_B forwards operand B untouched
  typedef enum logic [3:0] {
    ALU_ADD    = 4'd0,
    ALU_SUB    = 4'd1,
    ALU_SLL    = 4'd2,
    ALU_SLT    = 4'd3,
    ALU_SLTU   = 4'd4,
    ALU_XOR    = 4'd5,
    ALU_SRL    = 4'd6,
    ALU_SRA    = 4'd7,
    ALU_OR     = 4'd8,
    ALU_AND    = 4'd9,
    ALU_PASS_B = 4'd10
  } alu_op_e;

  // Where the PC goes after this instruction
  typedef enum logic [1:0] {
    PC_SEQ    = 2'd0,
    PC_BRANCH = 2'd1,
    PC_JUMP   = 2'd2
  } next_pc_sel_e;

endpackage

`default_nettype wire

/* source/fetch_unit.sv */
// Fetch stage: program memory loaded by the programmer port, byte PC
// and the fetch-to-decode register
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module fetch_unit (
  input  wire                   clock,
  input  wire                   i_rst_n,
  input  wire                   i_start,
  input  wire [`ADDR_BITS-1:0]  i_prog_address,
  input  wire                   i_isp_write,
  input  wire [`ADDR_BITS-1:0]  i_isp_address,
  input  wire [`XLEN-1:0]       i_isp_data,
  input  wire                   i_redirect,
  input  wire [`ADDR_BITS+1:0]  i_redirect_pc,
  output logic [`XLEN-1:0]      o_instr,
  output logic [`ADDR_BITS+1:0] o_pc,
  output logic                  o_valid,
  output logic [`ADDR_BITS+1:0] o_current_pc
);

  logic [`XLEN-1:0]      imem [0:`IMEM_WORDS-1];
  logic [`ADDR_BITS+1:0] pc;
  logic                  running;

  // Programmer write port
  always_ff @(posedge clock) begin
    if (i_isp_write) begin
      imem[i_isp_address] <= i_isp_data;
    end
  end

  // Start wins over a redirect, a redirect wins over the sequential step
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      pc      <= '0;
      running <= 1'b0;
    end else if (i_start) begin
      pc      <= {i_prog_address, 2'b00};
      running <= 1'b1;
    end else if (i_redirect) begin
      pc <= i_redirect_pc;
    end else if (running) begin
      pc <= pc + (`ADDR_BITS + 2)'(4);
    end
  end

  // Fetch-to-decode register
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_valid <= 1'b0;
    end else begin
      // The word fetched alongside a taken transfer is dropped
      o_valid <= running && !i_redirect && !i_start;
    end
  end

  always_ff @(posedge clock) begin
    o_instr <= imem[pc[`ADDR_BITS+1:2]];
    o_pc    <= pc;
  end

  assign o_current_pc = pc;

  // Program memory is only loaded while the core is idle
  a_no_isp_while_running: assert property (
    @(posedge clock) disable iff (!i_rst_n)
    i_isp_write |-> !running
  );

endmodule

`default_nettype wire

/* source/decode_unit.sv */
// Decode stage: control decode, immediates, register file, operand
// forwarding and the decode-to-execute register
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module decode_unit (
  input  wire                       clock,
  input  wire                       i_rst_n,
  input  wire [`XLEN-1:0]           i_instr,
  input  wire [`ADDR_BITS+1:0]      i_pc,
  input  wire                       i_valid,
  input  wire                       i_flush,
  input  wire                       i_ex_write,
  input  wire [`REG_SEL_BITS-1:0]   i_ex_rd,
  input  wire [`XLEN-1:0]           i_ex_data,
  input  wire                       i_wb_write,
  input  wire [`REG_SEL_BITS-1:0]   i_wb_rd,
  input  wire [`XLEN-1:0]           i_wb_data,
  output logic [`XLEN-1:0]          o_rs1_val,
  output logic [`XLEN-1:0]          o_rs2_val,
  output logic [`XLEN-1:0]          o_imm,
  output logic [`REG_SEL_BITS-1:0]  o_rd,
  output core_pkg::alu_op_e         o_alu_op,
  output core_pkg::next_pc_sel_e    o_next_pc_sel,
  output logic [2:0]                o_funct3,
  output logic                      o_regwrite,
  output logic [`ADDR_BITS+1:0]     o_pc,
  output logic                      o_valid
);

  import core_pkg::*;

  logic [`XLEN-1:0]         regs [0:(2**`REG_SEL_BITS)-1];
  logic [`REG_SEL_BITS-1:0] rs1;
  logic [`REG_SEL_BITS-1:0] rs2;
  logic [`REG_SEL_BITS-1:0] rd;
  logic [2:0]               funct3;
  logic                     alt;
  logic [`XLEN-1:0]         imm_i;
  logic [`XLEN-1:0]         imm_u;
  logic [`XLEN-1:0]         imm_b;
  logic [`XLEN-1:0]         imm_j;
  logic [`XLEN-1:0]         imm;
  logic [`XLEN-1:0]         rs1_fwd;
  logic [`XLEN-1:0]         rs2_fwd;
  opcode_e                  opcode;
  alu_op_e                  alu_op;
  next_pc_sel_e             next_pc_sel;
  logic                     legal;
  logic                     regwrite;
  logic                     b_is_imm;
  logic                     keep;

  assign rs1    = i_instr[19:15];
  assign rs2    = i_instr[24:20];
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign alt    = i_instr[30];

  assign imm_i = {{20{i_instr[31]}}, i_instr[31:20]};
  assign imm_u = {i_instr[31:12], 12'b0};
  assign imm_b = {{19{i_instr[31]}}, i_instr[31], i_instr[7], i_instr[30:25],
                  i_instr[11:8], 1'b0};
  assign imm_j = {{11{i_instr[31]}}, i_instr[31], i_instr[19:12], i_instr[20],
                  i_instr[30:21], 1'b0};

  function automatic alu_op_e funct_to_alu(input logic [2:0] f3, input logic use_alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = use_alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = use_alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // Priority: execute, then writeback, then the register file
  function automatic logic [`XLEN-1:0] forward_operand(
    input logic [`REG_SEL_BITS-1:0] sel,
    input logic [`XLEN-1:0]         rf_value
  );
    logic [`XLEN-1:0] value;
    if (sel == '0) begin
      value = '0;
    end else if (i_ex_write && (i_ex_rd == sel)) begin
      value = i_ex_data;
    end else if (i_wb_write && (i_wb_rd == sel)) begin
      value = i_wb_data;
    end else begin
      value = rf_value;
    end
    return value;
  endfunction

  always_comb begin
    case (i_instr[6:0])
      OPC_OP, OPC_OP_IMM, OPC_LUI, OPC_JAL, OPC_BRANCH: opcode = opcode_e'(i_instr[6:0]);
      default: opcode = OPC_ILLEGAL;
    endcase
  end

  always_comb begin
    legal       = 1'b1;
    regwrite    = 1'b0;
    alu_op      = ALU_ADD;
    next_pc_sel = PC_SEQ;
    imm         = imm_i;
    b_is_imm    = 1'b0;
    case (opcode)
      OPC_OP: begin
        regwrite = 1'b1;
        alu_op   = funct_to_alu(funct3, alt);
      end
      OPC_OP_IMM: begin
        // No SUBI, bit 30 only selects SRAI
        regwrite = 1'b1;
        alu_op   = funct_to_alu(funct3, alt && (funct3 == 3'b101));
        b_is_imm = 1'b1;
      end
      OPC_LUI: begin
        regwrite = 1'b1;
        alu_op   = ALU_PASS_B;
        imm      = imm_u;
        b_is_imm = 1'b1;
      end
      OPC_JAL: begin
        regwrite    = 1'b1;
        next_pc_sel = PC_JUMP;
        imm         = imm_j;
      end
      OPC_BRANCH: begin
        next_pc_sel = PC_BRANCH;
        imm         = imm_b;
      end
      default: legal = 1'b0;
    endcase
  end

  always_comb begin
    rs1_fwd = forward_operand(rs1, regs[rs1]);
    rs2_fwd = forward_operand(rs2, regs[rs2]);
  end

  // Register file, written from writeback
  always_ff @(posedge clock) begin
    if (i_wb_write) begin
      regs[i_wb_rd] <= i_wb_data;
    end
  end

  assign keep = i_valid && legal && !i_flush;

  // Decode-to-execute register
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_valid    <= 1'b0;
      o_regwrite <= 1'b0;
    end else begin
      o_valid    <= keep;
      o_regwrite <= keep && regwrite && (rd != '0);
    end
  end

  always_ff @(posedge clock) begin
    o_rs1_val     <= rs1_fwd;
    // Operand B carries the immediate for OP-IMM and LUI
    o_rs2_val     <= b_is_imm ? imm : rs2_fwd;
    o_imm         <= imm;
    o_rd          <= rd;
    o_alu_op      <= alu_op;
    o_next_pc_sel <= next_pc_sel;
    o_funct3      <= funct3;
    o_pc          <= i_pc;
  end

  // x0 writes are dropped here and must never come back from writeback
  a_no_x0_write: assert property (
    @(posedge clock) disable iff (!i_rst_n)
    i_wb_write |-> (i_wb_rd != '0)
  );

endmodule

`default_nettype wire

/* source/execution_unit.sv */
// Execute stage: ALU, branch compare, transfer target and the
// execute-to-writeback register
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module execution_unit (
  input  wire                      clock,
  input  wire                      i_rst_n,
  input  wire [`XLEN-1:0]          i_rs1_val,
  input  wire [`XLEN-1:0]          i_rs2_val,
  input  wire [`XLEN-1:0]          i_imm,
  input  wire [`REG_SEL_BITS-1:0]  i_rd,
  input  var core_pkg::alu_op_e    i_alu_op,
  input  var core_pkg::next_pc_sel_e i_next_pc_sel,
  input  wire [2:0]                i_funct3,
  input  wire                      i_regwrite,
  input  wire [`ADDR_BITS+1:0]     i_pc,
  input  wire                      i_valid,
  output logic                     o_ex_write,
  output logic [`REG_SEL_BITS-1:0] o_ex_rd,
  output logic [`XLEN-1:0]         o_ex_data,
  output logic                     o_redirect,
  output logic [`ADDR_BITS+1:0]    o_redirect_pc,
  output logic                     o_wb_write,
  output logic [`REG_SEL_BITS-1:0] o_wb_rd,
  output logic [`XLEN-1:0]         o_wb_data
);

  import core_pkg::*;

  logic [`XLEN-1:0]      alu_result;
  logic [`ADDR_BITS+1:0] link_pc;
  logic                  taken;

  always_comb begin
    case (i_alu_op)
      ALU_ADD:  alu_result = i_rs1_val + i_rs2_val;
      ALU_SUB:  alu_result = i_rs1_val - i_rs2_val;
      ALU_SLL:  alu_result = i_rs1_val << i_rs2_val[4:0];
      ALU_SLT:  alu_result = {{(`XLEN-1){1'b0}}, $signed(i_rs1_val) < $signed(i_rs2_val)};
      ALU_SLTU: alu_result = {{(`XLEN-1){1'b0}}, i_rs1_val < i_rs2_val};
      ALU_XOR:  alu_result = i_rs1_val ^ i_rs2_val;
      ALU_SRL:  alu_result = i_rs1_val >> i_rs2_val[4:0];
      ALU_SRA:  alu_result = $signed(i_rs1_val) >>> i_rs2_val[4:0];
      ALU_OR:   alu_result = i_rs1_val | i_rs2_val;
      ALU_AND:  alu_result = i_rs1_val & i_rs2_val;
      default:  alu_result = i_rs2_val;
    endcase
  end

  // Branch condition from funct3
  always_comb begin
    case (i_funct3)
      3'b000:  taken = (i_rs1_val == i_rs2_val);
      3'b001:  taken = (i_rs1_val != i_rs2_val);
      3'b100:  taken = $signed(i_rs1_val) < $signed(i_rs2_val);
      3'b101:  taken = $signed(i_rs1_val) >= $signed(i_rs2_val);
      3'b110:  taken = i_rs1_val < i_rs2_val;
      3'b111:  taken = i_rs1_val >= i_rs2_val;
      default: taken = 1'b0;
    endcase
  end

  assign link_pc = i_pc + (`ADDR_BITS + 2)'(4);

  // Result seen by decode for forwarding
  assign o_ex_write = i_valid && i_regwrite;
  assign o_ex_rd    = i_rd;
  assign o_ex_data  = (i_next_pc_sel == PC_JUMP) ?
                      {{(`XLEN-`ADDR_BITS-2){1'b0}}, link_pc} : alu_result;

  // Branch and JAL targets are both PC relative
  assign o_redirect_pc = i_pc + i_imm[`ADDR_BITS+1:0];
  assign o_redirect    = i_valid && ((i_next_pc_sel == PC_JUMP) ||
                                     ((i_next_pc_sel == PC_BRANCH) && taken));

  // Execute-to-writeback register
  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_wb_write <= 1'b0;
    end else begin
      o_wb_write <= o_ex_write;
    end
  end

  always_ff @(posedge clock) begin
    o_wb_rd   <= o_ex_rd;
    o_wb_data <= o_ex_data;
  end

  // A transfer comes from a real instruction and leaves two bubbles behind it
  a_redirect_squash: assert property (
    @(posedge clock) disable iff (!i_rst_n)
    o_redirect |-> i_valid ##1 !i_valid [*2]
  );

endmodule

`default_nettype wire

/* source/riscv_core.sv */
// RV32I core top level: fetch, decode and execute stages plus the
// peripheral register that reports writes to a0..a7
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module riscv_core (
  input  wire                   clock,
  input  wire                   i_rst_n,
  input  wire                   i_start,
  input  wire [`ADDR_BITS-1:0]  i_prog_address,
  input  wire                   i_isp_write,
  input  wire [`ADDR_BITS-1:0]  i_isp_address,
  input  wire [`XLEN-1:0]       i_isp_data,
  output logic [`ADDR_BITS+1:0] o_current_pc,
  output logic [`XLEN-1:0]      o_to_peripheral_data,
  output logic                  o_to_peripheral_valid
);

  import core_pkg::*;

  // Fetch to decode
  logic [`XLEN-1:0]         fd_instr;
  logic [`ADDR_BITS+1:0]    fd_pc;
  logic                     fd_valid;

  // Decode to execute
  logic [`XLEN-1:0]         de_rs1_val;
  logic [`XLEN-1:0]         de_rs2_val;
  logic [`XLEN-1:0]         de_imm;
  logic [`REG_SEL_BITS-1:0] de_rd;
  alu_op_e                  de_alu_op;
  next_pc_sel_e             de_next_pc_sel;
  logic [2:0]               de_funct3;
  logic                     de_regwrite;
  logic [`ADDR_BITS+1:0]    de_pc;
  logic                     de_valid;

  // Execute results, redirect and writeback
  logic                     ex_write;
  logic [`REG_SEL_BITS-1:0] ex_rd;
  logic [`XLEN-1:0]         ex_data;
  logic                     redirect;
  logic [`ADDR_BITS+1:0]    redirect_pc;
  logic                     wb_write;
  logic [`REG_SEL_BITS-1:0] wb_rd;
  logic [`XLEN-1:0]         wb_data;
  logic                     report;

  fetch_unit u_fetch (
    .clock          (clock),
    .i_rst_n        (i_rst_n),
    .i_start        (i_start),
    .i_prog_address (i_prog_address),
    .i_isp_write    (i_isp_write),
    .i_isp_address  (i_isp_address),
    .i_isp_data     (i_isp_data),
    .i_redirect     (redirect),
    .i_redirect_pc  (redirect_pc),
    .o_instr        (fd_instr),
    .o_pc           (fd_pc),
    .o_valid        (fd_valid),
    .o_current_pc   (o_current_pc)
  );

  decode_unit u_decode (
    .clock         (clock),
    .i_rst_n       (i_rst_n),
    .i_instr       (fd_instr),
    .i_pc          (fd_pc),
    .i_valid       (fd_valid),
    .i_flush       (redirect),
    .i_ex_write    (ex_write),
    .i_ex_rd       (ex_rd),
    .i_ex_data     (ex_data),
    .i_wb_write    (wb_write),
    .i_wb_rd       (wb_rd),
    .i_wb_data     (wb_data),
    .o_rs1_val     (de_rs1_val),
    .o_rs2_val     (de_rs2_val),
    .o_imm         (de_imm),
    .o_rd          (de_rd),
    .o_alu_op      (de_alu_op),
    .o_next_pc_sel (de_next_pc_sel),
    .o_funct3      (de_funct3),
    .o_regwrite    (de_regwrite),
    .o_pc          (de_pc),
    .o_valid       (de_valid)
  );

  execution_unit u_execute (
    .clock         (clock),
    .i_rst_n       (i_rst_n),
    .i_rs1_val     (de_rs1_val),
    .i_rs2_val     (de_rs2_val),
    .i_imm         (de_imm),
    .i_rd          (de_rd),
    .i_alu_op      (de_alu_op),
    .i_next_pc_sel (de_next_pc_sel),
    .i_funct3      (de_funct3),
    .i_regwrite    (de_regwrite),
    .i_pc          (de_pc),
    .i_valid       (de_valid),
    .o_ex_write    (ex_write),
    .o_ex_rd       (ex_rd),
    .o_ex_data     (ex_data),
    .o_redirect    (redirect),
    .o_redirect_pc (redirect_pc),
    .o_wb_write    (wb_write),
    .o_wb_rd       (wb_rd),
    .o_wb_data     (wb_data)
  );

  // Only a0..a7 are reported
  assign report = wb_write && (wb_rd >= `PERIPH_REG_FIRST) && (wb_rd <= `PERIPH_REG_LAST);

  always_ff @(posedge clock) begin
    if (!i_rst_n) begin
      o_to_peripheral_valid <= 1'b0;
    end else begin
      o_to_peripheral_valid <= report;
    end
  end

  always_ff @(posedge clock) begin
    if (report) begin
      o_to_peripheral_data <= wb_data;
    end
  end

endmodule

`default_nettype wire

/* test/tb_riscv_core.sv */
// Testbench for the RV32I core: programs it from the golden file and
// checks the stream of a0..a7 writes on the peripheral port
`timescale 1ns/100ps
`default_nettype none
`include "core_config.svh"

module tb_riscv_core;

  localparam int GOLDEN_DEPTH  = 64;
  localparam int PULSE_TIMEOUT = 200;
  localparam int WATCH_CYCLES  = 50;

  logic                  clock;
  logic                  i_rst_n;
  logic                  i_start;
  logic [`ADDR_BITS-1:0] i_prog_address;
  logic                  i_isp_write;
  logic [`ADDR_BITS-1:0] i_isp_address;
  logic [`XLEN-1:0]      i_isp_data;
  wire  [`ADDR_BITS+1:0] o_current_pc;
  wire  [`XLEN-1:0]      o_to_peripheral_data;
  wire                   o_to_peripheral_valid;

  // Word count, program, expected count, expected values
  logic [31:0] golden [0:GOLDEN_DEPTH-1];

  riscv_core DUT (
    .clock                 (clock),
    .i_rst_n               (i_rst_n),
    .i_start               (i_start),
    .i_prog_address        (i_prog_address),
    .i_isp_write           (i_isp_write),
    .i_isp_address         (i_isp_address),
    .i_isp_data            (i_isp_data),
    .o_current_pc          (o_current_pc),
    .o_to_peripheral_data  (o_to_peripheral_data),
    .o_to_peripheral_valid (o_to_peripheral_valid)
  );

  initial begin
    clock = 1'b0;
    forever #10 clock = ~clock;
  end

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
      $display("Finished with errors");
      $fatal(1, "Value mismatch");
    end
  endtask

  task automatic report_failure(input string reason);
    $display("%s", reason);
    $display("Finished with errors");
    $fatal(1, "Run aborted");
  endtask

  // One word per cycle through the programmer port, from address 0
  task automatic load_program(input int count);
    for (int i = 0; i < count; i++) begin
      @(posedge clock);
      i_isp_write   <= 1'b1;
      i_isp_address <= `ADDR_BITS'(i);
      i_isp_data    <= golden[i + 1];
    end
    @(posedge clock);
    i_isp_write <= 1'b0;
  endtask

  task automatic pulse_start(input logic [`ADDR_BITS-1:0] address);
    @(posedge clock);
    i_start        <= 1'b1;
    i_prog_address <= address;
    @(posedge clock);
    i_start <= 1'b0;
  endtask

  // Sampled at the falling edge, so back-to-back pulses are each seen once
  task automatic wait_for_pulse(input int index, output logic [31:0] data);
    int   cycles;
    logic seen;
    cycles = 0;
    seen   = 1'b0;
    while (!seen && cycles < PULSE_TIMEOUT) begin
      @(negedge clock);
      seen = o_to_peripheral_valid;
      cycles++;
    end
    if (!seen) begin
      report_failure($sformatf("Timed out waiting for peripheral write %0d", index));
    end else begin
      data = o_to_peripheral_data;
    end
  endtask

  initial begin : main_sequence
    int          word_count;
    int          expect_count;
    logic [31:0] data;
    i_rst_n        = 1'b0;
    i_start        = 1'b0;
    i_prog_address = '0;
    i_isp_write    = 1'b0;
    i_isp_address  = '0;
    i_isp_data     = '0;
    data           = '0;

    $readmemh("test/core_golden.txt", golden);
    word_count = golden[0];
    if (word_count < 1 || word_count > `IMEM_WORDS || word_count + 2 > GOLDEN_DEPTH) begin
      report_failure("The golden file has no usable program word count");
    end
    expect_count = golden[word_count + 1];
    if (word_count + 2 + expect_count > GOLDEN_DEPTH) begin
      report_failure("The golden file lists more expected values than it holds");
    end

    repeat (2) @(posedge clock);
    i_rst_n <= 1'b1;
    @(negedge clock);
    check_value("peripheral valid after reset", 32'd0, 32'(o_to_peripheral_valid));

    load_program(word_count);
    @(negedge clock);
    check_value("peripheral valid while idle", 32'd0, 32'(o_to_peripheral_valid));

    pulse_start('0);
    @(negedge clock);
    check_value("PC after start", 32'd0, 32'(o_current_pc));
    // Running core steps one word per cycle
    @(negedge clock);
    check_value("PC one cycle into the run", 32'd4, 32'(o_current_pc));

    // Every write to a0..a7 in program order
    for (int i = 0; i < expect_count; i++) begin
      wait_for_pulse(i, data);
      check_value($sformatf("peripheral write %0d", i), golden[word_count + 2 + i], data);
    end

    // Core now spins on its self-jump
    repeat (WATCH_CYCLES) begin
      @(negedge clock);
      check_value("no write after the last one", 32'd0, 32'(o_to_peripheral_valid));
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

`default_nettype wire

/* test/core_golden.txt */
// Program word count, program words from address 0, expected write count,
// then the expected a0..a7 writes in the order they reach the peripheral
00000024 // 36 program words
12345537 // lui  a0, 0x12345
67850593 // addi a1, a0, 0x678
40a58633 // sub  a2, a1, a0
ff000293 // addi t0, x0, -16
00c60033 // add  x0, a2, a2
4022d693 // srai a3, t0, 2
00d63733 // sltu a4, a2, a3
0006c7b3 // xor  a5, a3, x0
00f68463 // beq  a3, a5, +8   taken
00100893 // addi a7, x0, 1
00d60463 // beq  a2, a3, +8
00200893 // addi a7, x0, 2
00d61463 // bne  a2, a3, +8   taken
00300893 // addi a7, x0, 3
00f69463 // bne  a3, a5, +8
00400893 // addi a7, x0, 4
00c6c463 // blt  a3, a2, +8   taken
00500893 // addi a7, x0, 5
00d64463 // blt  a2, a3, +8
00600893 // addi a7, x0, 6
00d65463 // bge  a2, a3, +8   taken
00700893 // addi a7, x0, 7
00c6d463 // bge  a3, a2, +8
00800893 // addi a7, x0, 8
00d66463 // bltu a2, a3, +8   taken
00900893 // addi a7, x0, 9
00c6e463 // bltu a3, a2, +8
00a00893 // addi a7, x0, 10
00c6f463 // bgeu a3, a2, +8   taken
00b00893 // addi a7, x0, 11
00c77463 // bgeu a4, a2, +8
00c00893 // addi a7, x0, 12
0080086f // jal  a6, +8
06300893 // addi a7, x0, 99   skipped
00e808b3 // add  a7, a6, a4
0000006f // jal  x0, 0
0000000e // 14 expected writes
12345000 // a0
12345678 // a1
00000678 // a2
fffffffc // a3
00000001 // a4
fffffffc // a5
00000002 // a7, not-taken beq
00000004 // a7, not-taken bne
00000006 // a7, not-taken blt
00000008 // a7, not-taken bge
0000000a // a7, not-taken bltu
0000000c // a7, not-taken bgeu
00000084 // a6, link of the jal
00000085 // a7

/* riscv_core.f */
+incdir+source
source/core_pkg.sv
source/fetch_unit.sv
source/decode_unit.sv
source/execution_unit.sv
source/riscv_core.sv
test/tb_riscv_core.sv

/* run_sim.sh */
#!/bin/sh
# Builds the core testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
fail_text="Finished with errors"
pass_text="Finished with no errors"

verilator --binary --timing --assert -j 0 \
  -f riscv_core.f --top-module tb_riscv_core --Mdir "$build_dir"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$build_dir/Vtb_riscv_core" > "$log_file" 2>&1
run_status=$?
cat "$log_file"

if grep -q "$fail_text" "$log_file"; then
  echo "Simulation FAILED"
  exit 1
fi
if [ $run_status -ne 0 ]; then
  echo "Simulation exited with status $run_status"
  exit 1
fi
if ! grep -q "$pass_text" "$log_file"; then
  echo "Simulation ended without a result"
  exit 1
fi
echo "Simulation PASSED"
exit 0
